/* mc6809_regs.f */
verilog/cpu_regs_pkg.sv
verilog/ea_pkg.sv
verilog/ea_calc.sv
verilog/reg_file.sv
verilog/mc6809_regs_top.sv
verification/regs_asserts.sv
verification/tb_mc6809_regs.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the register file testbench with Verilator, runs it and scans the log
set -eo pipefail

cd "$(dirname "$0")"
LOG=sim.log

verilator --binary --timing --assert -f mc6809_regs.f \
	--top-module tb_mc6809_regs -Mdir obj_dir

./obj_dir/Vtb_mc6809_regs | tee "$LOG"

if grep -q "Testbench failed" "$LOG"; then
	echo "simulation reported a failure, see $LOG"
	exit 1
fi
echo "simulation finished without failure"

/* verification/tb_mc6809_regs.sv */
// directed testbench for the register file and indexed address unit, run via the file list
`timescale 1ns/1ps

module tb_mc6809_regs;

	localparam cpu_regs_pkg::word_t PC_INIT = 16'hc000;
	localparam cpu_regs_pkg::word_t S_INIT = 16'h7f00;
	localparam cpu_regs_pkg::word_t U_INIT = 16'h6e00;
	localparam cpu_regs_pkg::byte_t CC_INIT = 8'hd0;
	localparam int CYCLE_LIMIT = 5000;

	logic clk_in;
	logic rst_n;
	cpu_regs_pkg::reg_num_t left_sel, right_sel, write_sel, exg_dest;
	cpu_regs_pkg::reg_ctrl_t ctrl;
	ea_pkg::ea_req_t ea_req;
	cpu_regs_pkg::word_t data_w, new_pc;
	cpu_regs_pkg::ccr_t flags_in;
	cpu_regs_pkg::word_t left_data, right_data, pc, stack_ptr, ea_addr;
	cpu_regs_pkg::ccr_t ccr;
	cpu_regs_pkg::byte_t dp;

	// expected register contents
	cpu_regs_pkg::byte_t m_a, m_b, m_dp;
	cpu_regs_pkg::word_t m_x, m_y, m_u, m_s, m_pc;
	cpu_regs_pkg::ccr_t m_cc;
	int checks = 0;
	int errors = 0;
	int seed;

	mc6809_regs_top
	#(
		.RESET_PC(PC_INIT),
		.RESET_S(S_INIT),
		.RESET_U(U_INIT),
		.RESET_CCR(CC_INIT)
	)
	uut
	(
		.clk_in(clk_in), .rst_n(rst_n),
		.left_sel(left_sel), .right_sel(right_sel),
		.write_sel(write_sel), .exg_dest(exg_dest),
		.ctrl(ctrl), .ea_req(ea_req),
		.data_w(data_w), .new_pc(new_pc), .flags_in(flags_in),
		.left_data(left_data), .right_data(right_data),
		.ccr(ccr), .pc(pc), .dp(dp),
		.stack_ptr(stack_ptr), .ea_addr(ea_addr)
	);

	initial
	begin
		clk_in = 1'b0;
		forever #50 clk_in = ~clk_in;
	end

	// guards against a stuck run
	initial
	begin
		for (int cyc = 0; cyc < CYCLE_LIMIT; cyc++)
			@(posedge clk_in);
		$display("ERROR: run did not finish within %0d clock cycles", CYCLE_LIMIT);
		$display("Testbench failed");
		$finish;
	end

	task automatic check_word(input cpu_regs_pkg::word_t got, input cpu_regs_pkg::word_t exp,
			input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_byte(input cpu_regs_pkg::byte_t got, input cpu_regs_pkg::byte_t exp,
			input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_ccr(input cpu_regs_pkg::ccr_t got, input cpu_regs_pkg::ccr_t exp,
			input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAILED at %0t ns: %s flags EFHINZVC %b, expected %b", $time, what, got, exp);
		end
	endtask

	function automatic cpu_regs_pkg::word_t rand16();
		return cpu_regs_pkg::word_t'($urandom);
	endfunction

	function automatic cpu_regs_pkg::word_t sign8(input cpu_regs_pkg::byte_t v);
		return {{8{v[7]}}, v};
	endfunction

	// register read by number with 8-bit ones zero-extended
	function automatic cpu_regs_pkg::word_t model_read(input cpu_regs_pkg::reg_num_t num);
		case (num)
			cpu_regs_pkg::REG_D: return {m_a, m_b};
			cpu_regs_pkg::REG_X: return m_x;
			cpu_regs_pkg::REG_Y: return m_y;
			cpu_regs_pkg::REG_U: return m_u;
			cpu_regs_pkg::REG_S: return m_s;
			cpu_regs_pkg::REG_PC: return m_pc;
			cpu_regs_pkg::REG_A: return {8'h00, m_a};
			cpu_regs_pkg::REG_B: return {8'h00, m_b};
			cpu_regs_pkg::REG_CC: return {m_cc, m_cc};	// same byte twice
			cpu_regs_pkg::REG_DP: return {m_dp, m_dp};
			default: return 16'hffff;
		endcase
	endfunction

	task automatic model_write(input cpu_regs_pkg::reg_num_t num, input cpu_regs_pkg::word_t v);
		case (num)
			cpu_regs_pkg::REG_D: {m_a, m_b} = v;
			cpu_regs_pkg::REG_X: m_x = v;
			cpu_regs_pkg::REG_Y: m_y = v;
			cpu_regs_pkg::REG_U: m_u = v;
			cpu_regs_pkg::REG_S: m_s = v;
			cpu_regs_pkg::REG_PC: m_pc = v;
			cpu_regs_pkg::REG_A: m_a = v[7:0];
			cpu_regs_pkg::REG_B: m_b = v[7:0];
			cpu_regs_pkg::REG_CC: m_cc = v[7:0];
			cpu_regs_pkg::REG_DP: m_dp = v[7:0];
			default: ;
		endcase
	endtask

	function automatic cpu_regs_pkg::reg_num_t index_num(input logic [1:0] sel);
		case (sel)
			2'd0: return cpu_regs_pkg::REG_X;
			2'd1: return cpu_regs_pkg::REG_Y;
			2'd2: return cpu_regs_pkg::REG_U;
			default: return cpu_regs_pkg::REG_S;
		endcase
	endfunction

	// index register after +1, +2, -1 or -2
	function automatic cpu_regs_pkg::word_t step_value(input ea_pkg::postbyte_t p);
		cpu_regs_pkg::word_t base;
		base = model_read(index_num(p.index_sel));
		case (p.mode[1:0])
			2'd0: return base + 16'd1;
			2'd1: return base + 16'd2;
			2'd2: return base - 16'd1;
			default: return base - 16'd2;
		endcase
	endfunction

	function automatic cpu_regs_pkg::word_t expected_ea(input ea_pkg::ea_req_t r);
		cpu_regs_pkg::word_t base;
		logic [4:0] n5;
		base = model_read(index_num(r.postbyte.index_sel));
		n5 = {r.postbyte.indirect, r.postbyte.mode};
		if (!r.postbyte.long_form)
			return base + {{11{n5[4]}}, n5};
		case (ea_pkg::ea_mode_t'(r.postbyte.mode))
			ea_pkg::EA_POST_INC1, ea_pkg::EA_POST_INC2, ea_pkg::EA_NO_OFFSET: return base;
			ea_pkg::EA_PRE_DEC1, ea_pkg::EA_PRE_DEC2: return step_value(r.postbyte);
			ea_pkg::EA_B_OFFSET: return base + sign8(m_b);
			ea_pkg::EA_A_OFFSET: return base + sign8(m_a);
			ea_pkg::EA_OFFSET8: return base + sign8(r.offset[7:0]);
			ea_pkg::EA_OFFSET16: return base + r.offset;
			ea_pkg::EA_D_OFFSET: return base + {m_a, m_b};
			ea_pkg::EA_PC8: return m_pc + sign8(r.offset[7:0]);
			ea_pkg::EA_PC16: return m_pc + r.offset;
			default: return 16'hffff;	// undefined mode
		endcase
	endfunction

	// strobe for one cycle, then settle for checking
	task automatic strobe(input cpu_regs_pkg::reg_ctrl_t c);
		@(posedge clk_in);
		ctrl <= c;
		@(posedge clk_in);
		ctrl <= '0;
		@(negedge clk_in);
	endtask

	task automatic load(input cpu_regs_pkg::reg_num_t num, input cpu_regs_pkg::word_t v);
		cpu_regs_pkg::reg_ctrl_t c;
		c = '0;
		c.write_reg = 1'b1;
		@(posedge clk_in);
		write_sel <= num;
		data_w <= v;
		strobe(c);
		model_write(num, v);
	endtask

	task automatic read_pair(input cpu_regs_pkg::reg_num_t l, input cpu_regs_pkg::reg_num_t r);
		@(posedge clk_in);
		left_sel <= l;
		right_sel <= r;
		@(negedge clk_in);
		check_word(left_data, model_read(l), $sformatf("left port reg %0h", l));
		check_word(right_data, model_read(r), $sformatf("right port reg %0h", r));
	endtask

	// transfer src into dst, or swap both
	task automatic move(input cpu_regs_pkg::reg_num_t src, input cpu_regs_pkg::reg_num_t dst,
			input logic swap);
		cpu_regs_pkg::reg_ctrl_t c;
		cpu_regs_pkg::word_t src_val;
		cpu_regs_pkg::word_t dst_val;
		c = '0;
		c.write_tfr = !swap;
		c.write_exg = swap;
		src_val = model_read(src);
		dst_val = model_read(dst);
		@(posedge clk_in);
		left_sel <= src;
		right_sel <= dst;
		write_sel <= dst;
		exg_dest <= src;
		strobe(c);
		model_write(dst, src_val);
		if (swap)
			model_write(src, dst_val);
		read_pair(src, dst);
	endtask

	task automatic test_reset();
		cpu_regs_pkg::reg_ctrl_t c;
		m_a = '0;
		m_b = '0;
		m_dp = '0;
		m_x = '0;
		m_y = '0;
		m_u = U_INIT;
		m_s = S_INIT;
		m_pc = PC_INIT;
		m_cc = CC_INIT;
		check_word(pc, PC_INIT, "pc after reset");
		check_ccr(ccr, m_cc, "cc after reset");
		check_byte(dp, 8'h00, "dp after reset");
		check_word(stack_ptr, U_INIT, "stack_ptr with use_s low");
		c = '0;
		c.use_s = 1'b1;	// selects S without writing
		@(posedge clk_in);
		ctrl <= c;
		@(negedge clk_in);
		check_word(stack_ptr, S_INIT, "stack_ptr with use_s high");
		read_pair(cpu_regs_pkg::REG_A, cpu_regs_pkg::REG_B);
		read_pair(cpu_regs_pkg::REG_X, cpu_regs_pkg::REG_Y);
	endtask

	task automatic test_load();
		for (int n = 1; n < 12; n++)
			if (n != 6 && n != 7)
				load(cpu_regs_pkg::reg_num_t'(n[3:0]), rand16());
		for (int n = 0; n < 16; n++)
			read_pair(cpu_regs_pkg::reg_num_t'(n[3:0]), cpu_regs_pkg::reg_num_t'(4'(15 - n)));
		check_byte(dp, m_dp, "dp port after load");
		load(cpu_regs_pkg::REG_D, rand16());
		read_pair(cpu_regs_pkg::REG_A, cpu_regs_pkg::REG_B);
	endtask

	task automatic test_transfer();
		move(cpu_regs_pkg::REG_X, cpu_regs_pkg::REG_Y, 1'b0);
		move(cpu_regs_pkg::REG_D, cpu_regs_pkg::REG_DP, 1'b0);	// low byte lands in dp
		move(cpu_regs_pkg::REG_U, cpu_regs_pkg::REG_D, 1'b1);
		move(cpu_regs_pkg::REG_A, cpu_regs_pkg::REG_X, 1'b1);
	endtask

	task automatic test_pc_stack();
		cpu_regs_pkg::reg_ctrl_t c;
		cpu_regs_pkg::word_t v;
		cpu_regs_pkg::ccr_t f;
		c = '0;
		c.inc_pc = 1'b1;
		for (int i = 0; i < 3; i++)
		begin
			strobe(c);
			m_pc = m_pc + 16'd1;
			check_word(pc, m_pc, "pc after inc_pc");
		end
		v = rand16();
		c = '0;
		c.write_pc = 1'b1;
		@(posedge clk_in);
		new_pc <= v;
		strobe(c);
		check_word(pc, v, "pc after write_pc");
		m_pc = v;
		load(cpu_regs_pkg::REG_S, 16'hffff);
		load(cpu_regs_pkg::REG_U, 16'h0000);
		c = '0;
		c.inc_su = 1'b1;
		c.use_s = 1'b1;
		strobe(c);	// S wraps to zero
		c = '0;
		c.dec_su = 1'b1;
		strobe(c);	// U wraps to ffff
		m_s = 16'h0000;
		m_u = 16'hffff;
		read_pair(cpu_regs_pkg::REG_S, cpu_regs_pkg::REG_U);
		f = cpu_regs_pkg::ccr_t'(8'($urandom));
		f.e = 1'b0;	// so set_e has to raise it
		c = '0;
		c.write_flags = 1'b1;
		@(posedge clk_in);
		flags_in <= f;
		strobe(c);
		m_cc = f;
		check_ccr(ccr, m_cc, "cc after write_flags");
		c = '0;
		c.set_e = 1'b1;
		strobe(c);
		m_cc.e = 1'b1;
		check_ccr(ccr, m_cc, "cc after set_e");
		c = '0;
		c.clear_e = 1'b1;
		strobe(c);
		m_cc.e = 1'b0;
		check_ccr(ccr, m_cc, "cc after clear_e");
	endtask

	task automatic check_ea(input ea_pkg::ea_req_t r);
		@(posedge clk_in);
		ea_req <= r;
		@(negedge clk_in);
		check_word(ea_addr, expected_ea(r), $sformatf("ea for postbyte %h", r.postbyte));
	endtask

	task automatic test_indexed();
		ea_pkg::ea_req_t req;
		cpu_regs_pkg::reg_num_t idx_reg;
		cpu_regs_pkg::reg_ctrl_t c;
		cpu_regs_pkg::word_t exp;
		for (int sel = 0; sel < 4; sel++)
		begin
			idx_reg = index_num(sel[1:0]);
			load(cpu_regs_pkg::REG_A, rand16());
			load(cpu_regs_pkg::REG_B, rand16());
			for (int m = 0; m < 20; m++)
			begin
				load(idx_reg, rand16());
				req.postbyte.long_form = (m < 16);	// last four are short form
				req.postbyte.index_sel = sel[1:0];
				req.postbyte.indirect = (m < 16) ? 1'b0 : 1'($urandom);
				req.postbyte.mode = (m < 16) ? m[3:0] : 4'($urandom);
				req.offset = rand16();
				check_ea(req);
				if (m < 4)
				begin
					exp = step_value(req.postbyte);
					c = '0;
					c.write_post = 1'b1;
					strobe(c);
					model_write(idx_reg, exp);
					read_pair(idx_reg, cpu_regs_pkg::REG_D);
				end
			end
		end
	endtask

	initial
	begin
		seed = $urandom(32'ha9b4);
		rst_n = 1'b0;
		left_sel = cpu_regs_pkg::REG_D;
		right_sel = cpu_regs_pkg::REG_D;
		write_sel = cpu_regs_pkg::REG_D;
		exg_dest = cpu_regs_pkg::REG_D;
		ctrl = '0;
		ea_req = '0;
		data_w = '0;
		new_pc = '0;
		flags_in = '0;
		for (int i = 0; i < 4; i++)
			@(posedge clk_in);
		rst_n <= 1'b1;
		@(negedge clk_in);
		test_reset();
		test_load();
		test_transfer();
		test_pc_stack();
		test_indexed();
		$display("checks run %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

/* verification/regs_asserts.sv */
// assertion checker bound into every reg_file instance, watches strobes and the reset value
`timescale 1ns/1ps

module regs_asserts
#(
	parameter cpu_regs_pkg::word_t RESET_PC = 16'h0000
)
(
	input logic clk_in,
	input logic rst_n,
	input cpu_regs_pkg::reg_ctrl_t ctrl,
	input cpu_regs_pkg::word_t pc
);

	step_excl: assert property (@(posedge clk_in) disable iff (!rst_n)
		!(ctrl.inc_su && ctrl.dec_su))	// one stack direction
		else $error("inc_su and dec_su high in the same cycle");

	e_excl: assert property (@(posedge clk_in) disable iff (!rst_n)
		!(ctrl.set_e && ctrl.clear_e))
		else $error("set_e and clear_e high in the same cycle");

	reset_pc: assert property (@(posedge clk_in) !rst_n |=> pc == RESET_PC)
		else $error("pc is %h after reset, expected %h", pc, RESET_PC);

endmodule

bind reg_file regs_asserts #(.RESET_PC(RESET_PC)) u_regs_asserts
(
	.clk_in(clk_in),
	.rst_n(rst_n),
	.ctrl(ctrl),
	.pc(pc)
);

/* verilog/mc6809_regs_top.sv */
// top of the register and indexed addressing block, sets reset values and joins both units
`timescale 1ns/1ps

module mc6809_regs_top
#(
	parameter cpu_regs_pkg::word_t RESET_PC = 16'hfffe,
	parameter cpu_regs_pkg::word_t RESET_S = 16'h0f00,
	parameter cpu_regs_pkg::word_t RESET_U = 16'h0e00,
	parameter cpu_regs_pkg::byte_t RESET_CCR = 8'h50
)
(
	input logic clk_in,
	input logic rst_n,
	input cpu_regs_pkg::reg_num_t left_sel,
	input cpu_regs_pkg::reg_num_t right_sel,
	input cpu_regs_pkg::reg_num_t write_sel,
	input cpu_regs_pkg::reg_num_t exg_dest,
	input cpu_regs_pkg::reg_ctrl_t ctrl,
	input ea_pkg::ea_req_t ea_req,
	input cpu_regs_pkg::word_t data_w,
	input cpu_regs_pkg::word_t new_pc,
	input cpu_regs_pkg::ccr_t flags_in,
	output cpu_regs_pkg::word_t left_data,
	output cpu_regs_pkg::word_t right_data,
	output cpu_regs_pkg::ccr_t ccr,
	output cpu_regs_pkg::word_t pc,
	output cpu_regs_pkg::byte_t dp,
	output cpu_regs_pkg::word_t stack_ptr,
	output cpu_regs_pkg::word_t ea_addr
);

	cpu_regs_pkg::index_regs_t index_regs;
	ea_pkg::ea_result_t ea_result;

	reg_file
	#(
		.RESET_PC(RESET_PC),
		.RESET_S(RESET_S),
		.RESET_U(RESET_U),
		.RESET_CCR(RESET_CCR)
	)
	u_reg_file
	(
		.clk_in(clk_in),
		.rst_n(rst_n),
		.left_sel(left_sel),
		.right_sel(right_sel),
		.write_sel(write_sel),
		.exg_dest(exg_dest),
		.index_sel(ea_req.postbyte.index_sel),	// post-write target
		.ctrl(ctrl),
		.stepped(ea_result.stepped),
		.data_w(data_w),
		.new_pc(new_pc),
		.flags_in(flags_in),
		.left_data(left_data),
		.right_data(right_data),
		.index_regs(index_regs),
		.ccr(ccr),
		.pc(pc),
		.dp(dp),
		.stack_ptr(stack_ptr)
	);

	ea_calc u_ea_calc
	(
		.req(ea_req),
		.regs(index_regs),
		.result(ea_result)
	);

	assign ea_addr = ea_result.addr;

endmodule

/* verilog/reg_file.sv */
// MC6809 register set with two read ports, load and exchange ports, stack step and flag writes
`timescale 1ns/1ps

module reg_file
#(
	parameter cpu_regs_pkg::word_t RESET_PC = 16'hfffe,
	parameter cpu_regs_pkg::word_t RESET_S = 16'h0000,
	parameter cpu_regs_pkg::word_t RESET_U = 16'h0000,
	parameter cpu_regs_pkg::byte_t RESET_CCR = 8'h50	// F and I set
)
(
	input logic clk_in,
	input logic rst_n,
	input cpu_regs_pkg::reg_num_t left_sel,
	input cpu_regs_pkg::reg_num_t right_sel,
	input cpu_regs_pkg::reg_num_t write_sel,
	input cpu_regs_pkg::reg_num_t exg_dest,
	input logic [1:0] index_sel,
	input cpu_regs_pkg::reg_ctrl_t ctrl,
	input cpu_regs_pkg::word_t stepped,
	input cpu_regs_pkg::word_t data_w,
	input cpu_regs_pkg::word_t new_pc,
	input cpu_regs_pkg::ccr_t flags_in,
	output cpu_regs_pkg::word_t left_data,
	output cpu_regs_pkg::word_t right_data,
	output cpu_regs_pkg::index_regs_t index_regs,
	output cpu_regs_pkg::ccr_t ccr,
	output cpu_regs_pkg::word_t pc,
	output cpu_regs_pkg::byte_t dp,
	output cpu_regs_pkg::word_t stack_ptr
);

	// complete register state, D lives in a:b
	typedef struct packed
	{
		cpu_regs_pkg::byte_t a;
		cpu_regs_pkg::byte_t b;
		cpu_regs_pkg::word_t x;
		cpu_regs_pkg::word_t y;
		cpu_regs_pkg::word_t u;
		cpu_regs_pkg::word_t s;
		cpu_regs_pkg::word_t pc;
		cpu_regs_pkg::byte_t dp;
		cpu_regs_pkg::ccr_t cc;
	} regset_t;

	localparam regset_t REG_RESET = '{
		a: 8'h00,
		b: 8'h00,
		x: 16'h0000,
		y: 16'h0000,
		u: RESET_U,
		s: RESET_S,
		pc: RESET_PC,
		dp: 8'h00,
		cc: RESET_CCR
	};

	regset_t cur;
	regset_t nxt;
	cpu_regs_pkg::word_t pc_plus_1;
	cpu_regs_pkg::word_t exg_val;
	cpu_regs_pkg::reg_num_t exg_target;
	cpu_regs_pkg::word_t load_val;

	// 16-bit view of any register number
	function automatic cpu_regs_pkg::word_t read_reg(input regset_t r,
			input cpu_regs_pkg::reg_num_t num);
		case (num)
			cpu_regs_pkg::REG_D: return {r.a, r.b};
			cpu_regs_pkg::REG_X: return r.x;
			cpu_regs_pkg::REG_Y: return r.y;
			cpu_regs_pkg::REG_U: return r.u;
			cpu_regs_pkg::REG_S: return r.s;
			cpu_regs_pkg::REG_PC: return r.pc;
			cpu_regs_pkg::REG_A: return {8'h00, r.a};
			cpu_regs_pkg::REG_B: return {8'h00, r.b};
			cpu_regs_pkg::REG_CC: return {r.cc, r.cc};	// both bytes
			cpu_regs_pkg::REG_DP: return {r.dp, r.dp};
			default: return 16'hffff;
		endcase
	endfunction

	// 8-bit targets take the low byte
	function automatic regset_t put_reg(input regset_t r_in,
			input cpu_regs_pkg::reg_num_t num, input cpu_regs_pkg::word_t val);
		regset_t r;
		r = r_in;
		case (num)
			cpu_regs_pkg::REG_D: {r.a, r.b} = val;
			cpu_regs_pkg::REG_X: r.x = val;
			cpu_regs_pkg::REG_Y: r.y = val;
			cpu_regs_pkg::REG_U: r.u = val;
			cpu_regs_pkg::REG_S: r.s = val;
			cpu_regs_pkg::REG_PC: r.pc = val;
			cpu_regs_pkg::REG_A: r.a = val[7:0];
			cpu_regs_pkg::REG_B: r.b = val[7:0];
			cpu_regs_pkg::REG_CC: r.cc = val[7:0];
			cpu_regs_pkg::REG_DP: r.dp = val[7:0];
			default: r = r_in;	// unused numbers write nothing
		endcase
		return r;
	endfunction

	assign left_data = read_reg(cur, left_sel);
	assign right_data = read_reg(cur, right_sel);

	assign pc_plus_1 = cur.pc + 16'h0001;
	assign exg_val = ctrl.inc_pc ? pc_plus_1 : right_data;
	assign exg_target = (ctrl.inc_pc | ctrl.write_pc) ? cpu_regs_pkg::REG_PC : exg_dest;
	assign load_val = (ctrl.write_tfr | ctrl.write_exg) ? left_data : data_w;

	// later writes win on the same register
	always_comb
	begin
		nxt = cur;
		if (ctrl.write_exg | ctrl.inc_pc)
			nxt = put_reg(nxt, exg_target, exg_val);
		if (ctrl.write_reg | ctrl.write_tfr | ctrl.write_exg)
			nxt = put_reg(nxt, write_sel, load_val);
		if (ctrl.write_post)
		begin
			case (index_sel)
				2'b00: nxt.x = stepped;
				2'b01: nxt.y = stepped;
				2'b10: nxt.u = stepped;
				default: nxt.s = stepped;
			endcase
		end
		if (ctrl.write_flags)
			nxt.cc = flags_in;
		if (ctrl.set_e | ctrl.clear_e)
			nxt.cc.e = ctrl.set_e;	// set has priority
		if (ctrl.write_pc)
			nxt.pc = new_pc;
		if (ctrl.inc_su)
		begin
			if (ctrl.use_s)
				nxt.s = cur.s + 16'h0001;
			else
				nxt.u = cur.u + 16'h0001;
		end
		else if (ctrl.dec_su)
		begin
			if (ctrl.use_s)
				nxt.s = cur.s - 16'h0001;
			else
				nxt.u = cur.u - 16'h0001;
		end
	end

	always_ff @(posedge clk_in)
	begin
		if (!rst_n)
			cur <= REG_RESET;
		else
			cur <= nxt;
	end

	assign index_regs.a = cur.a;
	assign index_regs.b = cur.b;
	assign index_regs.x = cur.x;
	assign index_regs.y = cur.y;
	assign index_regs.u = cur.u;
	assign index_regs.s = cur.s;
	assign index_regs.pc = cur.pc;

	assign ccr = cur.cc;
	assign pc = cur.pc;
	assign dp = cur.dp;
	assign stack_ptr = ctrl.use_s ? cur.s : cur.u;	// active stack

endmodule

/* verilog/ea_calc.sv */
// combinational indexed-mode address calculator, fed by the register file and the postbyte
`timescale 1ns/1ps

module ea_calc
(
	input ea_pkg::ea_req_t req,
	input cpu_regs_pkg::index_regs_t regs,
	output ea_pkg::ea_result_t result
);

	ea_pkg::postbyte_t pb;
	ea_pkg::ea_mode_t mode;
	cpu_regs_pkg::word_t base;	// selected index register
	cpu_regs_pkg::word_t stepped;
	cpu_regs_pkg::word_t off5;
	cpu_regs_pkg::word_t off8;
	cpu_regs_pkg::word_t addr;

	function automatic cpu_regs_pkg::word_t sext8(input cpu_regs_pkg::byte_t v);
		return {{8{v[7]}}, v};
	endfunction

	assign pb = req.postbyte;
	assign mode = ea_pkg::ea_mode_t'(pb.mode);
	assign off5 = {{11{pb.indirect}}, pb.indirect, pb.mode};	// sign in bit 4
	assign off8 = sext8(req.offset[7:0]);

	always_comb
	begin
		case (pb.index_sel)
			2'b00: base = regs.x;
			2'b01: base = regs.y;
			2'b10: base = regs.u;
			default: base = regs.s;
		endcase
	end

	// auto increment or decrement amount from low mode bits
	always_comb
	begin
		case (pb.mode[1:0])
			2'b00: stepped = base + 16'h0001;
			2'b01: stepped = base + 16'h0002;
			2'b10: stepped = base - 16'h0001;
			default: stepped = base - 16'h0002;
		endcase
	end

	always_comb
	begin
		if (!pb.long_form)
			addr = base + off5;	// n,R with 5-bit n
		else
		begin
			case (mode)
				ea_pkg::EA_POST_INC1,
				ea_pkg::EA_POST_INC2,
				ea_pkg::EA_NO_OFFSET:
					addr = base;	// step happens on write-back
				ea_pkg::EA_PRE_DEC1,
				ea_pkg::EA_PRE_DEC2:
					addr = stepped;
				ea_pkg::EA_B_OFFSET: addr = base + sext8(regs.b);
				ea_pkg::EA_A_OFFSET: addr = base + sext8(regs.a);
				ea_pkg::EA_D_OFFSET: addr = base + {regs.a, regs.b};
				ea_pkg::EA_OFFSET8: addr = base + off8;
				ea_pkg::EA_OFFSET16: addr = base + req.offset;
				ea_pkg::EA_PC8: addr = regs.pc + off8;
				ea_pkg::EA_PC16: addr = regs.pc + req.offset;
				default: addr = 16'hffff;	// undefined postbyte
			endcase
		end
	end

	assign result.addr = addr;
	assign result.stepped = stepped;

endmodule

/* verilog/ea_pkg.sv */
// indexed addressing definitions used by the address unit, the register file top and testbench
package ea_pkg;

	// indexed postbyte, short form keeps a 5-bit offset in {indirect, mode}
	typedef struct packed
	{
		logic long_form;
		logic [1:0] index_sel;	// X, Y, U, S
		logic indirect;	// carried only
		logic [3:0] mode;
	} postbyte_t;

	// long form modes, low two bits also give the auto step
	typedef enum logic [3:0]
	{
		EA_POST_INC1 = 4'h0,
		EA_POST_INC2 = 4'h1,
		EA_PRE_DEC1  = 4'h2,
		EA_PRE_DEC2  = 4'h3,
		EA_NO_OFFSET = 4'h4,
		EA_B_OFFSET  = 4'h5,
		EA_A_OFFSET  = 4'h6,
		EA_OFFSET8   = 4'h8,
		EA_OFFSET16  = 4'h9,
		EA_D_OFFSET  = 4'hb,
		EA_PC8       = 4'hc,
		EA_PC16      = 4'hd
	} ea_mode_t;

	typedef struct packed
	{
		postbyte_t postbyte;
		cpu_regs_pkg::word_t offset;	// bytes following the postbyte
	} ea_req_t;

	typedef struct packed
	{
		cpu_regs_pkg::word_t addr;	// effective address
		cpu_regs_pkg::word_t stepped;	// index after auto step
	} ea_result_t;

endpackage

/* verilog/cpu_regs_pkg.sv */
// register architecture definitions shared by the register file, address unit and testbench
package cpu_regs_pkg;

	typedef logic [15:0] word_t;	// data or address value
	typedef logic [7:0] byte_t;	// 8-bit register value

	// register numbers as used by TFR/EXG postbytes
	typedef enum logic [3:0]
	{
		REG_D  = 4'h0,
		REG_X  = 4'h1,
		REG_Y  = 4'h2,
		REG_U  = 4'h3,
		REG_S  = 4'h4,
		REG_PC = 4'h5,
		REG_A  = 4'h8,
		REG_B  = 4'h9,
		REG_CC = 4'ha,
		REG_DP = 4'hb
	} reg_num_t;

	typedef struct packed
	{
		logic e;	// entire state saved
		logic f;	// firq mask
		logic h;	// half carry
		logic i;	// irq mask
		logic n;
		logic z;
		logic v;
		logic c;
	} ccr_t;

	// write strobes from the sequencer, one cycle each
	typedef struct packed
	{
		logic write_reg;
		logic write_post;	// auto step write-back
		logic write_pc;
		logic write_tfr;
		logic write_exg;
		logic inc_pc;
		logic inc_su;
		logic dec_su;
		logic use_s;	// selects S over U
		logic write_flags;
		logic set_e;
		logic clear_e;
	} reg_ctrl_t;

	// values the indexed address unit reads
	typedef struct packed
	{
		byte_t a;
		byte_t b;
		word_t x;
		word_t y;
		word_t u;
		word_t s;
		word_t pc;
	} index_regs_t;

endpackage
